// ==== Bender.yml ====
package:
  name: arith_core

sources:
  - src/arith_pkg.sv
  - src/inst_decoder.sv
  - src/regfile_pending.sv
  - src/decode_issue.sv
  - src/alu_pipe.sv
  - src/mul_pipe.sv
  - src/complete_arbiter.sv
  - src/arith_core.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/arith_core_checker.sv
      - tb/arith_core_tb.sv

// ==== arith_core.f ====
src/arith_pkg.sv
src/inst_decoder.sv
src/regfile_pending.sv
src/decode_issue.sv
src/alu_pipe.sv
src/mul_pipe.sv
src/complete_arbiter.sv
src/arith_core.sv
tb/tb_clock.sv
tb/arith_core_checker.sv
tb/arith_core_tb.sv

// ==== src/alu_pipe.sv ====
// Single-cycle integer ALU pipe
// Result register stays full until the completion arbiter grants it

`timescale 1ns/1ps

module alu_pipe (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue_valid,
  output logic                 issue_ready,
  input  arith_pkg::issue_t    issue,
  output logic                 req_valid,
  input  logic                 req_ready,
  output arith_pkg::complete_t req
);
  import arith_pkg::*;

  logic [31:0] result;
  logic [4:0]  shamt;

  assign shamt = issue.op2[4:0];

  always_comb begin
    case (issue.uop)
      UOP_ADD:  result = issue.op1 + issue.op2;
      UOP_SUB:  result = issue.op1 - issue.op2;
      UOP_AND:  result = issue.op1 & issue.op2;
      UOP_OR:   result = issue.op1 | issue.op2;
      UOP_XOR:  result = issue.op1 ^ issue.op2;
      UOP_SLT:  result = {31'd0, $signed(issue.op1) < $signed(issue.op2)};
      UOP_SLTU: result = {31'd0, issue.op1 < issue.op2};
      UOP_SLL:  result = issue.op1 << shamt;
      UOP_SRL:  result = issue.op1 >> shamt;
      UOP_SRA:  result = $unsigned($signed(issue.op1) >>> shamt);
      UOP_LUI:  result = issue.op2;
      default:  result = 32'd0;
    endcase
  end

  // Accept when empty or draining this cycle
  assign issue_ready = ~req_valid | req_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
    end else if (issue_valid && issue_ready) begin
      req_valid <= 1'b1;
    end else if (req_ready) begin
      req_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid && issue_ready) begin
      req <= '{waddr: issue.waddr, wdata: result, seq: issue.seq};
    end
  end

endmodule

// ==== src/arith_core.sv ====
// Arithmetic core top
// Decode-issue with scoreboarded register file, ALU and multiply pipes,
// and one shared completion bus that is also the result stream

`timescale 1ns/1ps

module arith_core (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 fetch_valid,
  output logic                 fetch_ready,
  input  arith_pkg::fetch_t    fetch,
  output logic                 complete_valid,
  output arith_pkg::complete_t complete
);
  import arith_pkg::*;

  // Register file ports
  logic [4:0]  raddr0;
  logic [4:0]  raddr1;
  logic [31:0] rdata0;
  logic [31:0] rdata1;
  logic        rpend0;
  logic        rpend1;
  logic [4:0]  check_addr;
  logic        check_pend;
  logic        set_valid;
  logic [4:0]  set_addr;

  // Issue side
  issue_t      issue;
  logic        alu_valid;
  logic        alu_ready;
  logic        mul_valid;
  logic        mul_ready;

  // Pipe completion requests
  logic        alu_req_valid;
  logic        alu_req_ready;
  complete_t   alu_req;
  logic        mul_req_valid;
  complete_t   mul_req;

  // ------------------------------
  // Decode and register file
  // ------------------------------

  decode_issue u_decode_issue (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch       (fetch),
    .raddr0      (raddr0),
    .raddr1      (raddr1),
    .rdata0      (rdata0),
    .rdata1      (rdata1),
    .rpend0      (rpend0),
    .rpend1      (rpend1),
    .check_addr  (check_addr),
    .check_pend  (check_pend),
    .set_valid   (set_valid),
    .set_addr    (set_addr),
    .alu_valid   (alu_valid),
    .alu_ready   (alu_ready),
    .mul_valid   (mul_valid),
    .mul_ready   (mul_ready),
    .issue       (issue)
  );

  regfile_pending u_regfile (
    .clk            (clk),
    .rst            (rst),
    .raddr0         (raddr0),
    .raddr1         (raddr1),
    .rdata0         (rdata0),
    .rdata1         (rdata1),
    .rpend0         (rpend0),
    .rpend1         (rpend1),
    .check_addr     (check_addr),
    .check_pend     (check_pend),
    .set_valid      (set_valid),
    .set_addr       (set_addr),
    .complete_valid (complete_valid),
    .complete       (complete)
  );

  // ------------------------------
  // Execute pipes and completion
  // ------------------------------

  alu_pipe u_alu (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (alu_valid),
    .issue_ready (alu_ready),
    .issue       (issue),
    .req_valid   (alu_req_valid),
    .req_ready   (alu_req_ready),
    .req         (alu_req)
  );

  mul_pipe u_mul (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (mul_valid),
    .issue_ready (mul_ready),
    .issue       (issue),
    .req_valid   (mul_req_valid),
    .req         (mul_req)
  );

  complete_arbiter u_arb (
    .alu_valid      (alu_req_valid),
    .alu_ready      (alu_req_ready),
    .alu_req        (alu_req),
    .mul_valid      (mul_req_valid),
    .mul_req        (mul_req),
    .complete_valid (complete_valid),
    .complete       (complete)
  );

endmodule

// ==== src/arith_pkg.sv ====
// Arithmetic core package
// Shared widths, RV32 opcode fields, the micro-op encoding and the
// packed payloads used between fetch, issue and completion

package arith_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------

  localparam int SEQ_BITS   = 8;
  localparam int NUM_REGS   = 32;
  localparam int MUL_STAGES = 3;

  // RV32 major opcodes in the subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct7 groups of register-register ops
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // ------------------------------
  // Micro-ops
  // ------------------------------

  // Immediate forms reuse the register uops
  typedef enum logic [3:0] {
    UOP_ADD,
    UOP_SUB,
    UOP_AND,
    UOP_OR,
    UOP_XOR,
    UOP_SLT,
    UOP_SLTU,
    UOP_SLL,
    UOP_SRL,
    UOP_SRA,
    UOP_MUL,
    UOP_LUI
  } uop_e;

  // ------------------------------
  // Payloads
  // ------------------------------

  typedef struct packed {
    logic [31:0]         inst;
    logic [31:0]         pc;
    logic [SEQ_BITS-1:0] seq;
  } fetch_t;

  typedef struct packed {
    logic [31:0]         pc;
    logic [31:0]         op1;
    logic [31:0]         op2;
    uop_e                uop;
    logic [4:0]          waddr;
    logic [SEQ_BITS-1:0] seq;
  } issue_t;

  typedef struct packed {
    logic [4:0]          waddr;
    logic [31:0]         wdata;
    logic [SEQ_BITS-1:0] seq;
  } complete_t;

endpackage

// ==== src/complete_arbiter.sv ====
// Completion arbiter
// Fixed priority, multiply pipe first; ALU waits while mul owns the bus

`timescale 1ns/1ps

module complete_arbiter (
  // ALU pipe
  input  logic                 alu_valid,
  output logic                 alu_ready,
  input  arith_pkg::complete_t alu_req,
  // Multiply pipe, never back-pressured
  input  logic                 mul_valid,
  input  arith_pkg::complete_t mul_req,
  // Shared completion bus
  output logic                 complete_valid,
  output arith_pkg::complete_t complete
);

  // ------------------------------
  // Grant
  // ------------------------------

  // ALU only while mul is idle
  assign alu_ready = ~mul_valid;

  assign complete_valid = mul_valid | alu_valid;

  // Mux onto the bus
  always_comb begin
    if (mul_valid) begin
      complete = mul_req;
    end else begin
      complete = alu_req;
    end
  end

endmodule

// ==== src/decode_issue.sv ====
// Decode and issue stage
// Holds one fetched instruction, decodes it, stalls on RAW and WAW
// hazards against the scoreboard and routes it to the ALU or mul pipe

`timescale 1ns/1ps

module decode_issue (
  input  logic              clk,
  input  logic              rst,
  // Fetch side
  input  logic              fetch_valid,
  output logic              fetch_ready,
  input  arith_pkg::fetch_t fetch,
  // Register file reads and scoreboard
  output logic [4:0]        raddr0,
  output logic [4:0]        raddr1,
  input  logic [31:0]       rdata0,
  input  logic [31:0]       rdata1,
  input  logic              rpend0,
  input  logic              rpend1,
  output logic [4:0]        check_addr,
  input  logic              check_pend,
  output logic              set_valid,
  output logic [4:0]        set_addr,
  // Pipe side
  output logic              alu_valid,
  input  logic              alu_ready,
  output logic              mul_valid,
  input  logic              mul_ready,
  output arith_pkg::issue_t issue
);
  import arith_pkg::*;

  logic        hold_valid;
  fetch_t      hold;
  logic        dec_valid;
  uop_e        dec_uop;
  logic [4:0]  dec_waddr;
  logic        dec_uses_rs2;
  logic        dec_imm_sel;
  logic [31:0] dec_imm;
  logic        stall;
  logic        can_issue;
  logic        is_mul;
  logic        issue_fire;

  // ------------------------------
  // Holding register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      hold_valid <= 1'b0;
    end else if (fetch_valid && fetch_ready) begin
      hold_valid <= 1'b1;
    end else if (issue_fire) begin
      hold_valid <= 1'b0;
    end
  end

  // Payload, only loads on a transfer
  always_ff @(posedge clk) begin
    if (fetch_valid && fetch_ready) hold <= fetch;
  end

  inst_decoder u_dec (
    .inst        (hold.inst),
    .valid       (dec_valid),
    .uop         (dec_uop),
    .raddr0      (raddr0),
    .raddr1      (raddr1),
    .waddr       (dec_waddr),
    .uses_rs2    (dec_uses_rs2),
    .imm_sel_op2 (dec_imm_sel),
    .imm         (dec_imm)
  );

  // ------------------------------
  // Hazards and routing
  // ------------------------------

  // RAW on either used source, WAW on the destination
  assign check_addr = dec_waddr;
  assign stall      = rpend0 | (dec_uses_rs2 & rpend1) | check_pend;
  assign can_issue  = hold_valid & dec_valid & ~stall;
  assign is_mul     = (dec_uop == UOP_MUL);

  assign alu_valid  = can_issue & ~is_mul;
  assign mul_valid  = can_issue & is_mul;
  assign issue_fire = (alu_valid & alu_ready) | (mul_valid & mul_ready);

  // Empty, or emptying this cycle
  assign fetch_ready = ~hold_valid | issue_fire;

  // Mark destination busy on issue
  assign set_valid = issue_fire & (dec_waddr != 5'd0);
  assign set_addr  = dec_waddr;

  // Shared issue bus for both pipes
  assign issue.pc    = hold.pc;
  assign issue.op1   = rdata0;
  assign issue.op2   = dec_imm_sel ? dec_imm : rdata1;
  assign issue.uop   = dec_uop;
  assign issue.waddr = dec_waddr;
  assign issue.seq   = hold.seq;

endmodule

// ==== src/inst_decoder.sv ====
// RV32 arithmetic decoder
// Maps opcode, funct3 and funct7 onto a micro-op, register fields and
// the I-type or U-type immediate

`timescale 1ns/1ps

module inst_decoder (
  input  logic [31:0]     inst,
  output logic            valid,
  output arith_pkg::uop_e uop,
  output logic [4:0]      raddr0,
  output logic [4:0]      raddr1,
  output logic [4:0]      waddr,
  output logic            uses_rs2,
  output logic            imm_sel_op2,
  output logic [31:0]     imm
);
  import arith_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Instruction fields
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    // Defaults fit R-type, I-type immediate
    valid       = 1'b0;
    uop         = UOP_ADD;
    raddr0      = inst[19:15];
    raddr1      = inst[24:20];
    waddr       = inst[11:7];
    uses_rs2    = 1'b0;
    imm_sel_op2 = 1'b0;
    imm         = {{20{inst[31]}}, inst[31:20]};
    case (opcode)
      OPC_OP: begin
        uses_rs2 = 1'b1;
        if (funct7 == F7_MULDIV) begin
          // Only mul, low word
          valid = (funct3 == 3'b000);
          uop   = UOP_MUL;
        end else if (funct7 == F7_BASE) begin
          valid = 1'b1;
          case (funct3)
            3'b000:  uop = UOP_ADD;
            3'b001:  uop = UOP_SLL;
            3'b010:  uop = UOP_SLT;
            3'b011:  uop = UOP_SLTU;
            3'b100:  uop = UOP_XOR;
            3'b101:  uop = UOP_SRL;
            3'b110:  uop = UOP_OR;
            default: uop = UOP_AND;
          endcase
        end else if (funct7 == F7_ALT) begin
          valid = (funct3 == 3'b000) || (funct3 == 3'b101);
          uop   = (funct3 == 3'b101) ? UOP_SRA : UOP_SUB;
        end
      end
      OPC_OP_IMM: begin
        imm_sel_op2 = 1'b1;
        raddr1      = 5'd0;
        valid       = 1'b1;
        case (funct3)
          3'b000:  uop = UOP_ADD;
          3'b010:  uop = UOP_SLT;
          3'b100:  uop = UOP_XOR;
          3'b110:  uop = UOP_OR;
          3'b111:  uop = UOP_AND;
          // Shift and sltiu immediates are outside the subset
          default: valid = 1'b0;
        endcase
      end
      OPC_LUI: begin
        // x0 as op1, immediate passes through as op2
        valid       = 1'b1;
        uop         = UOP_LUI;
        raddr0      = 5'd0;
        raddr1      = 5'd0;
        imm_sel_op2 = 1'b1;
        imm         = {inst[31:12], 12'b0};
      end
      default: valid = 1'b0;
    endcase
  end

endmodule

// ==== src/mul_pipe.sv ====
// Three-stage multiply pipe
// Low 32 bits of op1 * op2 from 16-bit partial products, one new
// multiply per cycle, never stalled

`timescale 1ns/1ps

module mul_pipe (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue_valid,
  output logic                 issue_ready,
  input  arith_pkg::issue_t    issue,
  output logic                 req_valid,
  output arith_pkg::complete_t req
);
  import arith_pkg::*;

  logic [MUL_STAGES-1:0] vld;
  logic [4:0]            waddr_q [MUL_STAGES];
  logic [SEQ_BITS-1:0]   seq_q   [MUL_STAGES];

  // Stage data
  logic [31:0] pp_ll;
  logic [15:0] pp_lh;
  logic [15:0] pp_hl;
  logic [31:0] lo_q;
  logic [15:0] cross_q;
  logic [31:0] prod_q;

  // Priority on the completion bus, so always ready
  assign issue_ready = 1'b1;

  // ------------------------------
  // Control shift chain
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      vld <= '0;
    end else begin
      vld <= {vld[MUL_STAGES-2:0], issue_valid & issue_ready};
    end
  end

  always_ff @(posedge clk) begin
    waddr_q[0] <= issue.waddr;
    seq_q[0]   <= issue.seq;
    for (int s = 1; s < MUL_STAGES; s++) begin
      waddr_q[s] <= waddr_q[s-1];
      seq_q[s]   <= seq_q[s-1];
    end
  end

  // ------------------------------
  // Datapath
  // ------------------------------

  always_ff @(posedge clk) begin
    // S1 partial products, hi*hi drops out of the low word
    pp_ll   <= issue.op1[15:0] * issue.op2[15:0];
    pp_lh   <= 16'(issue.op1[15:0] * issue.op2[31:16]);
    pp_hl   <= 16'(issue.op1[31:16] * issue.op2[15:0]);
    // S2 cross terms summed
    lo_q    <= pp_ll;
    cross_q <= pp_lh + pp_hl;
    // S3 final add
    prod_q  <= lo_q + {cross_q, 16'd0};
  end

  assign req_valid = vld[MUL_STAGES-1];
  assign req       = '{waddr: waddr_q[MUL_STAGES-1], wdata: prod_q,
                       seq: seq_q[MUL_STAGES-1]};

endmodule

// ==== src/regfile_pending.sv ====
// Register file with pending scoreboard
// 32 words, two read ports, one destination check port, written by
// the completion bus; x0 reads zero and is never pending

`timescale 1ns/1ps

module regfile_pending (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [4:0]           raddr0,
  input  logic [4:0]           raddr1,
  output logic [31:0]          rdata0,
  output logic [31:0]          rdata1,
  output logic                 rpend0,
  output logic                 rpend1,
  input  logic [4:0]           check_addr,
  output logic                 check_pend,
  input  logic                 set_valid,
  input  logic [4:0]           set_addr,
  input  logic                 complete_valid,
  input  arith_pkg::complete_t complete
);
  import arith_pkg::*;

  logic [31:0]         regs [NUM_REGS];
  logic [NUM_REGS-1:0] pend;

  // Completion write, x0 ignored
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (complete_valid && complete.waddr != 5'd0) begin
      regs[complete.waddr] <= complete.wdata;
    end
  end

  // Scoreboard, set after clear so a younger issue wins
  always_ff @(posedge clk) begin
    if (rst) begin
      pend <= '0;
    end else begin
      if (complete_valid) pend[complete.waddr] <= 1'b0;
      if (set_valid && set_addr != 5'd0) pend[set_addr] <= 1'b1;
    end
  end

  // Asynchronous reads
  assign rdata0     = (raddr0 == 5'd0) ? 32'd0 : regs[raddr0];
  assign rdata1     = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  assign rpend0     = pend[raddr0];
  assign rpend1     = pend[raddr1];
  assign check_pend = pend[check_addr];

endmodule

// ==== tb/arith_core_checker.sv ====
// Completion checker
// Replays every fetch transfer on a model register file in program order
// and compares each completion by its sequence number

`timescale 1ns/1ps

module arith_core_checker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 fetch_valid,
  input  logic                 fetch_ready,
  input  arith_pkg::fetch_t    fetch,
  input  logic                 complete_valid,
  input  arith_pkg::complete_t complete,
  output int                   err_count,
  output int                   n_transfers,
  output int                   n_completions
);
  import arith_pkg::*;

  localparam int SEQ_SPACE = 1 << SEQ_BITS;

  // Model state
  logic [31:0] model_regs [NUM_REGS];
  logic [4:0]  exp_waddr  [SEQ_SPACE];
  logic [31:0] exp_wdata  [SEQ_SPACE];
  logic        outstanding [SEQ_SPACE];

  // ------------------------------
  // Reference model
  // ------------------------------

  // Result of one instruction from the RV32 rules
  function automatic logic [31:0] model_result(input logic [31:0] inst);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    opc = inst[6:0];
    f3  = inst[14:12];
    f7  = inst[31:25];
    a   = (inst[19:15] == 5'd0) ? 32'd0 : model_regs[inst[19:15]];
    // Register or sign-extended I immediate
    if (opc == 7'b0110011) begin
      b = (inst[24:20] == 5'd0) ? 32'd0 : model_regs[inst[24:20]];
    end else begin
      b = {{20{inst[31]}}, inst[31:20]};
    end
    r = 32'd0;
    if (opc == 7'b0110111) begin
      r = {inst[31:12], 12'd0};
    end else if (opc == 7'b0110011 && f7 == 7'b0000001) begin
      // Low word, same for signed and unsigned
      r = a * b;
    end else if (opc == 7'b0110011 && f7 == 7'b0100000) begin
      if (f3 == 3'b101) begin
        r = $signed(a) >>> b[4:0];
      end else begin
        r = a - b;
      end
    end else begin
      case (f3)
        3'b000:  r = a + b;
        3'b001:  r = a << b[4:0];
        3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  r = (a < b) ? 32'd1 : 32'd0;
        3'b100:  r = a ^ b;
        3'b101:  r = a >> b[4:0];
        3'b110:  r = a | b;
        default: r = a & b;
      endcase
    end
    return r;
  endfunction

  // ------------------------------
  // Monitor
  // ------------------------------

  always @(posedge clk) begin
    logic [SEQ_BITS-1:0] s;
    logic [31:0]         res;
    if (rst) begin
      err_count     = 0;
      n_transfers   = 0;
      n_completions = 0;
      for (int i = 0; i < NUM_REGS; i++) model_regs[i] = 32'd0;
      for (int i = 0; i < SEQ_SPACE; i++) outstanding[i] = 1'b0;
    end else begin
      // Completion side first, seqs differ from this edge's transfer
      if (complete_valid) begin
        s = complete.seq;
        if (!outstanding[s]) begin
          $display("ERR %0t: completion for seq %0d with nothing outstanding", $time, s);
          err_count++;
        end else begin
          if (complete.waddr !== exp_waddr[s] || complete.wdata !== exp_wdata[s]) begin
            $display("ERR %0t: seq %0d got x%0d=%h, expected x%0d=%h", $time, s,
                     complete.waddr, complete.wdata, exp_waddr[s], exp_wdata[s]);
            err_count++;
          end
          outstanding[s] = 1'b0;
        end
        n_completions++;
      end
      // Program order update of the model
      if (fetch_valid && fetch_ready) begin
        s   = fetch.seq;
        res = model_result(fetch.inst);
        if (outstanding[s]) begin
          $display("ERR %0t: seq %0d reused while still outstanding", $time, s);
          err_count++;
        end
        exp_waddr[s]   = fetch.inst[11:7];
        exp_wdata[s]   = res;
        outstanding[s] = 1'b1;
        // x0 stays zero
        if (fetch.inst[11:7] != 5'd0) model_regs[fetch.inst[11:7]] = res;
        n_transfers++;
      end
    end
  end

endmodule

// ==== tb/arith_core_tb.sv ====
// Arithmetic core testbench
// Random instruction stream over x0..x7 with gaps, drain wait and report

`timescale 1ns/1ps

module arith_core_tb;
  import arith_pkg::*;

  localparam int NUM_INSTS      = 400;
  localparam int READY_TIMEOUT  = 200;
  localparam int DRAIN_TIMEOUT  = 500;
  localparam int RESET_TIMEOUT  = 50;

  logic      clk;
  logic      rst;
  logic      fetch_valid;
  logic      fetch_ready;
  fetch_t    fetch;
  logic      complete_valid;
  complete_t complete;

  int          seed;
  int          timeouts;
  int          err_count;
  int          n_transfers;
  int          n_completions;
  int          waited;
  logic [31:0] inst;
  logic        stuck;

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  arith_core u_dut (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid    (fetch_valid),
    .fetch_ready    (fetch_ready),
    .fetch          (fetch),
    .complete_valid (complete_valid),
    .complete       (complete)
  );

  arith_core_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid    (fetch_valid),
    .fetch_ready    (fetch_ready),
    .fetch          (fetch),
    .complete_valid (complete_valid),
    .complete       (complete),
    .err_count      (err_count),
    .n_transfers    (n_transfers),
    .n_completions  (n_completions)
  );

  // ------------------------------
  // Stimulus helpers
  // ------------------------------

  // One random instruction, a quarter of them mul
  task automatic random_inst(output logic [31:0] word);
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    int         kind;
    int         idx;
    logic [2:0] f3;
    logic [6:0] f7;
    rd   = 5'({$random(seed)} % 8);
    rs1  = 5'({$random(seed)} % 8);
    rs2  = 5'({$random(seed)} % 8);
    kind = {$random(seed)} % 8;
    idx  = {$random(seed)} % 10;
    f7   = 7'b0000000;
    if (kind < 2) begin
      word = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
    end else if (kind < 5) begin
      // add sub and or xor slt sltu sll srl sra
      case (idx)
        0: f3 = 3'b000;
        1: begin f3 = 3'b000; f7 = 7'b0100000; end
        2: f3 = 3'b111;
        3: f3 = 3'b110;
        4: f3 = 3'b100;
        5: f3 = 3'b010;
        6: f3 = 3'b011;
        7: f3 = 3'b001;
        8: f3 = 3'b101;
        default: begin f3 = 3'b101; f7 = 7'b0100000; end
      endcase
      word = {f7, rs2, rs1, f3, rd, 7'b0110011};
    end else if (kind < 7) begin
      // addi slti xori ori andi
      case (idx % 5)
        0: f3 = 3'b000;
        1: f3 = 3'b010;
        2: f3 = 3'b100;
        3: f3 = 3'b110;
        default: f3 = 3'b111;
      endcase
      word = {12'($random(seed)), rs1, f3, rd, 7'b0010011};
    end else begin
      word = {20'($random(seed)), rd, 7'b0110111};
    end
  endtask

  // Hold one instruction valid until accepted
  task automatic send_inst(input logic [31:0] word);
    int wait_cycles;
    fetch_valid = 1'b1;
    fetch.inst  = word;
    wait_cycles = 0;
    // fetch_ready only follows DUT state, stable between edges
    while (!fetch_ready && wait_cycles < READY_TIMEOUT) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!fetch_ready) begin
      $display("Timeout at %0t: fetch_ready stayed low for seq %0d", $time, fetch.seq);
      timeouts++;
      stuck       = 1'b1;
      fetch_valid = 1'b0;
    end else begin
      @(negedge clk);
      fetch_valid = 1'b0;
      fetch.seq   = fetch.seq + 1'b1;
      fetch.pc    = fetch.pc + 32'd4;
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    seed        = 18;
    timeouts    = 0;
    stuck       = 1'b0;
    fetch_valid = 1'b0;
    fetch       = '0;

    waited = 0;
    @(negedge clk);
    while (rst && waited < RESET_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (rst) begin
      $display("Timeout: reset never released");
      timeouts++;
      stuck = 1'b1;
    end

    for (int n = 0; n < NUM_INSTS && !stuck; n++) begin
      // Random idle gap
      if (({$random(seed)} % 4) == 0) begin
        repeat (1 + {$random(seed)} % 3) @(negedge clk);
      end
      random_inst(inst);
      send_inst(inst);
    end

    // Drain
    waited = 0;
    while (n_completions != n_transfers && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (n_completions != n_transfers) begin
      $display("Timeout: %0d transfers but only %0d completions after drain",
               n_transfers, n_completions);
      timeouts++;
    end
    if (n_transfers != NUM_INSTS) begin
      $display("Only %0d of %0d instructions were transferred", n_transfers, NUM_INSTS);
      timeouts++;
    end

    $display("Errors: %0d mismatches, %0d timeouts (%0d transfers, %0d completions)",
             err_count, timeouts, n_transfers, n_completions);
    if (err_count == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tb/tb_clock.sv ====
// Testbench clock and reset
// 40 ns clock, reset high for the first 5 cycles

`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    // Released on the 5th edge
    rst <= 1'b0;
  end

endmodule
